// ==== logic/fixed_point_pkg.sv ====
package fixed_point_pkg;

	//////////////////////////////////////////////////
	// 4.23 two's complement coordinates
	//////////////////////////////////////////////////

	localparam int COORD_BITS = 27;
	localparam int FRAC_BITS  = 23;

	// Used for c, z and the per-pixel step
	typedef logic signed [COORD_BITS-1:0] coord_t;

	// Each zoom level halves the step
	typedef logic [4:0] zoom_t;

	// About 0.00464 per pixel at zoom 0
	localparam coord_t BASE_STEP = coord_t'(39000);

	//////////////////////////////////////////////////
	// Escape limits
	//////////////////////////////////////////////////

	// 4.0, compared against |z|^2
	localparam coord_t ESCAPE_MAG_SQ = coord_t'(4 << FRAC_BITS);

	// 2.0, bound on each part of z
	localparam coord_t ESCAPE_COMPONENT = coord_t'(2 << FRAC_BITS);

endpackage

// ==== logic/render_pkg.sv ====
package render_pkg;

	// RGB 3-3-2
	typedef logic [7:0] color_t;

	// Frame level control
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT,
		FINISH
	} frame_state_t;

	// Per-pixel iterator
	typedef enum logic [1:0] {
		ITER_IDLE,
		ITER_CALC,
		ITER_DONE
	} iter_state_t;

	//////////////////////////////////////////////////
	// Escape count to colour
	//////////////////////////////////////////////////

	// Bands by powers of two of the iteration limit
	function automatic color_t palette_color(input int unsigned count,
			input int unsigned iter_max);
		color_t color;
		// Never escaped, inside the set
		if (count >= iter_max)
			color = 8'b000_000_00;
		else if (count >= (iter_max >> 1))
			color = 8'b011_001_00;
		// Same shade as the band above
		else if (count >= (iter_max >> 2))
			color = 8'b011_001_00;
		else if (count >= (iter_max >> 3))
			color = 8'b101_010_01;
		else if (count >= (iter_max >> 4))
			color = 8'b011_001_01;
		else if (count >= (iter_max >> 5))
			color = 8'b001_001_01;
		else if (count >= (iter_max >> 6))
			color = 8'b011_010_10;
		// Fast escapes
		else
			color = 8'b010_100_10;
		return color;
	endfunction

endpackage

// ==== logic/iterate_if.sv ====
`timescale 1ns/1ps

interface iterate_if #(
	parameter int ITER_MAX = 1000
);
	import fixed_point_pkg::*;

	localparam int CNT_W = $clog2(ITER_MAX) + 1;

	// Point to test, driven straight from the scanner at the top level
	coord_t c_re;
	coord_t c_im;

	// Start/ready to hand over c, done/ack to return the count
	logic start;
	logic ready;
	logic done;
	logic ack;
	logic [CNT_W-1:0] count;

	modport requester (output start, output ack, input ready, input done, input count);

	modport worker (input c_re, input c_im, input start, input ack,
		output ready, output done, output count);

endinterface

// ==== logic/escape_iterator.sv ====
`timescale 1ns/1ps

module escape_iterator (
	input logic clk,
	input logic reset,
	iterate_if.worker it
);
	import fixed_point_pkg::*;
	import render_pkg::*;

	localparam int ITER_MAX = it.ITER_MAX;
	localparam int CNT_W = $clog2(ITER_MAX) + 1;
	localparam coord_t ESC_LOW = -ESCAPE_COMPONENT;

	// Full product, then sign bit plus the 26 bits around the binary point
	function automatic coord_t fx_mul(input coord_t a, input coord_t b);
		logic signed [2*COORD_BITS-1:0] prod;
		prod = a * b;
		return {prod[2*COORD_BITS-1], prod[COORD_BITS+FRAC_BITS-2:FRAC_BITS]};
	endfunction

	iter_state_t state;

	// Latched point, running z and its squares
	coord_t c_re;
	coord_t c_im;
	coord_t zr;
	coord_t zi;
	coord_t zr_sq;
	coord_t zi_sq;
	logic [CNT_W-1:0] count;

	coord_t zr_zi;
	coord_t zr_next;
	coord_t zi_next;
	coord_t zr_sq_next;
	coord_t zi_sq_next;
	coord_t mag_sq;
	logic escape;

	//////////////////////////////////////////////////
	// One Mandelbrot step
	//////////////////////////////////////////////////

	assign zr_zi = fx_mul(zr, zi);

	// z^2 + c, squares come from the registers
	assign zr_next = zr_sq - zi_sq + c_re;
	assign zi_next = (zr_zi <<< 1) + c_im;

	// Squares of the new z, kept for the next step
	assign zr_sq_next = fx_mul(zr_next, zr_next);
	assign zi_sq_next = fx_mul(zi_next, zi_next);

	// Magnitude from the new squares
	assign mag_sq = zr_sq_next + zi_sq_next;

	assign escape = (mag_sq > ESCAPE_MAG_SQ)
		|| (zr_next > ESCAPE_COMPONENT) || (zr_next < ESC_LOW)
		|| (zi_next > ESCAPE_COMPONENT) || (zi_next < ESC_LOW)
		|| (count == CNT_W'(ITER_MAX - 1));

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ITER_IDLE;
		end else begin
			case (state)
				ITER_IDLE: if (it.start) state <= ITER_CALC;
				ITER_CALC: if (escape) state <= ITER_DONE;
				// Hold the result until the requester takes it
				ITER_DONE: if (it.ack) state <= ITER_IDLE;
				default: state <= ITER_IDLE;
			endcase
		end
	end

	// Datapath, z starts at the origin
	always_ff @(posedge clk) begin
		if (state == ITER_IDLE && it.start) begin
			c_re <= it.c_re;
			c_im <= it.c_im;
			zr <= '0;
			zi <= '0;
			zr_sq <= '0;
			zi_sq <= '0;
			count <= '0;
		end else if (state == ITER_CALC) begin
			zr <= zr_next;
			zi <= zi_next;
			zr_sq <= zr_sq_next;
			zi_sq <= zi_sq_next;
			count <= count + 1'b1;
		end
	end

	assign it.ready = (state == ITER_IDLE);
	assign it.done = (state == ITER_DONE);
	assign it.count = count;

endmodule

// ==== logic/pixel_scanner.sv ====
`timescale 1ns/1ps

module pixel_scanner #(
	parameter int FRAME_WIDTH = 640,
	parameter int FRAME_HEIGHT = 480,
	localparam int ADDR_W = $clog2(FRAME_WIDTH * FRAME_HEIGHT)
) (
	input logic clk,
	input logic reset,
	input logic load,
	input logic advance,
	input fixed_point_pkg::coord_t x_start,
	input fixed_point_pkg::coord_t y_start,
	input fixed_point_pkg::zoom_t zoom,
	output fixed_point_pkg::coord_t c_re,
	output fixed_point_pkg::coord_t c_im,
	output logic [ADDR_W-1:0] pix_addr,
	output logic last
);
	import fixed_point_pkg::*;

	localparam int COL_W = $clog2(FRAME_WIDTH);
	localparam int ROW_W = $clog2(FRAME_HEIGHT);
	localparam logic [COL_W-1:0] COL_LAST = COL_W'(FRAME_WIDTH - 1);
	localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(FRAME_HEIGHT - 1);

	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;

	// Kept for the start of each row
	coord_t x_origin;
	// Same step for x and y
	coord_t step;

	//////////////////////////////////////////////////
	// Position and address counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
			pix_addr <= '0;
		end else if (load) begin
			col <= '0;
			row <= '0;
			pix_addr <= '0;
		end else if (advance) begin
			pix_addr <= pix_addr + 1'b1;
			if (col == COL_LAST) begin
				col <= '0;
				row <= (row == ROW_LAST) ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Complex plane walk
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (load) begin
			c_re <= x_start;
			c_im <= y_start;
			x_origin <= x_start;
			// Arithmetic shift keeps the sign
			step <= BASE_STEP >>> zoom;
		end else if (advance) begin
			// Rows run top to bottom, so imaginary part falls
			if (col == COL_LAST) begin
				c_re <= x_origin;
				c_im <= c_im - step;
			end else begin
				c_re <= c_re + step;
			end
		end
	end

	assign last = (col == COL_LAST) && (row == ROW_LAST);

endmodule

// ==== logic/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer #(
	parameter int ITER_MAX = 1000
) (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic last,
	iterate_if.requester it,
	output logic load,
	output logic advance,
	output logic pix_we,
	output render_pkg::color_t pix_color,
	output logic frame_busy,
	output logic frame_done
);
	import render_pkg::*;

	frame_state_t state;

	logic accept;

	// New frame only when not busy
	assign accept = frame_start && (state == IDLE || state == FINISH);

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			pix_we <= 1'b0;
		end else begin
			// One write per result, the cycle after done is seen
			pix_we <= (state == WAIT) && it.done && !pix_we;
			case (state)
				IDLE, FINISH: if (accept) state <= ISSUE;
				ISSUE: if (it.ready) state <= WAIT;
				// Leave on the write cycle
				WAIT: begin
					if (pix_we)
						state <= last ? FINISH : ISSUE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Colour of the returned count, lined up with pix_we
	always_ff @(posedge clk) begin
		if (state == WAIT && it.done && !pix_we)
			pix_color <= palette_color(32'(it.count), ITER_MAX);
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// Scanner picks up the start point on the accept cycle
	assign load = accept;

	assign it.start = (state == ISSUE);

	// Release the iterator and step the scanner as the pixel is written
	assign it.ack = pix_we;
	assign advance = pix_we;

	assign frame_busy = (state == ISSUE) || (state == WAIT);
	assign frame_done = (state == FINISH);

endmodule

// ==== logic/mandelbrot_renderer.sv ====
`timescale 1ns/1ps

module mandelbrot_renderer #(
	parameter int FRAME_WIDTH = 640,
	parameter int FRAME_HEIGHT = 480,
	parameter int ITER_MAX = 1000,
	localparam int ADDR_W = $clog2(FRAME_WIDTH * FRAME_HEIGHT)
) (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input fixed_point_pkg::zoom_t zoom,
	input fixed_point_pkg::coord_t x_start,
	input fixed_point_pkg::coord_t y_start,
	output logic frame_busy,
	output logic frame_done,
	output logic pix_we,
	output logic [ADDR_W-1:0] pix_addr,
	output render_pkg::color_t pix_color
);

	logic load;
	logic advance;
	logic last;

	iterate_if #(.ITER_MAX(ITER_MAX)) iter_bus ();

	// Coordinates go straight onto the iterator bus
	pixel_scanner #(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT)
	) u_pixel_scanner (
		.clk(clk),
		.reset(reset),
		.load(load),
		.advance(advance),
		.x_start(x_start),
		.y_start(y_start),
		.zoom(zoom),
		.c_re(iter_bus.c_re),
		.c_im(iter_bus.c_im),
		.pix_addr(pix_addr),
		.last(last)
	);

	frame_sequencer #(
		.ITER_MAX(ITER_MAX)
	) u_frame_sequencer (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.last(last),
		.it(iter_bus.requester),
		.load(load),
		.advance(advance),
		.pix_we(pix_we),
		.pix_color(pix_color),
		.frame_busy(frame_busy),
		.frame_done(frame_done)
	);

	escape_iterator u_escape_iterator (
		.clk(clk),
		.reset(reset),
		.it(iter_bus.worker)
	);

endmodule

// ==== bench/renderer_model.svh ====
`ifndef RENDERER_MODEL_SVH
`define RENDERER_MODEL_SVH

//////////////////////////////////////////////////
// Reference model of the renderer
//////////////////////////////////////////////////

localparam int REF_W = 27;
localparam int REF_FRAC = 23;

// Signed 4.23
typedef logic signed [REF_W-1:0] ref_coord_t;

localparam ref_coord_t REF_BASE_STEP = ref_coord_t'(39000);
// 2.0 and 4.0
localparam ref_coord_t REF_TWO = ref_coord_t'(2 << REF_FRAC);
localparam ref_coord_t REF_FOUR = ref_coord_t'(4 << REF_FRAC);

// Full product cut to sign plus bits 48..23
function automatic ref_coord_t ref_mul(input ref_coord_t a, input ref_coord_t b);
	longint p;
	p = longint'(a) * longint'(b);
	return {p[63], p[48:23]};
endfunction

// Iterations until escape, ITER_MAX when never escaped
function automatic int ref_escape_count(input ref_coord_t cr, input ref_coord_t ci);
	ref_coord_t zr;
	ref_coord_t zi;
	ref_coord_t sr;
	ref_coord_t si;
	ref_coord_t nr;
	ref_coord_t ni;
	ref_coord_t mag;
	int n;
	bit escaped;
	zr = '0;
	zi = '0;
	n = 0;
	escaped = 1'b0;
	while (!escaped) begin
		sr = ref_mul(zr, zr);
		si = ref_mul(zi, zi);
		nr = sr - si + cr;
		ni = (ref_mul(zr, zi) <<< 1) + ci;
		// Magnitude of the new z
		mag = ref_mul(nr, nr) + ref_mul(ni, ni);
		escaped = (mag > REF_FOUR) || (nr > REF_TWO) || (nr < -REF_TWO)
			|| (ni > REF_TWO) || (ni < -REF_TWO) || (n == ITER_MAX - 1);
		zr = nr;
		zi = ni;
		n++;
	end
	return n;
endfunction

// Bands at ITER_MAX over powers of two
function automatic logic [7:0] ref_palette(input int n, input int m);
	if (n >= m) return 8'b000_000_00;
	if (n >= (m >> 1)) return 8'b011_001_00;
	if (n >= (m >> 2)) return 8'b011_001_00;
	if (n >= (m >> 3)) return 8'b101_010_01;
	if (n >= (m >> 4)) return 8'b011_001_01;
	if (n >= (m >> 5)) return 8'b001_001_01;
	if (n >= (m >> 6)) return 8'b011_010_10;
	return 8'b010_100_10;
endfunction

// Complex point of a linear pixel address
function automatic void ref_point(input ref_coord_t x0, input ref_coord_t y0,
		input logic [4:0] zoom, input int addr,
		output ref_coord_t re, output ref_coord_t im);
	ref_coord_t step;
	int col;
	int row;
	step = REF_BASE_STEP >>> zoom;
	col = addr % FRAME_WIDTH;
	row = addr / FRAME_WIDTH;
	// Real part grows along a row, imaginary part falls per row
	re = x0 + ref_coord_t'(col) * step;
	im = y0 - ref_coord_t'(row) * step;
endfunction

`endif

// ==== bench/renderer_tb.sv ====
`timescale 1ns/1ps

module renderer_tb;

	localparam int FRAME_WIDTH = 16;
	localparam int FRAME_HEIGHT = 12;
	localparam int ITER_MAX = 64;
	localparam int PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
	localparam int ADDR_W = $clog2(PIXELS);
	localparam int NUM_FRAMES = 4;
	localparam int CLK_PERIOD = 40;
	// Worst case per pixel plus slack for reset and gaps
	localparam longint WATCHDOG_NS =
		longint'(NUM_FRAMES) * PIXELS * (ITER_MAX + 4) * CLK_PERIOD + 200000;

	`include "renderer_model.svh"

	// -2.0 and 1.1 for the first frame
	localparam ref_coord_t X_FIRST = -ref_coord_t'(2 << REF_FRAC);
	localparam ref_coord_t Y_FIRST = ref_coord_t'(9227469);
	// Near the cardioid neck, -0.75 and 0.3
	localparam ref_coord_t X_RAND_BASE = -ref_coord_t'(6291456);
	localparam ref_coord_t Y_RAND_BASE = ref_coord_t'(2516582);

	logic clk;
	logic reset;
	logic frame_start;
	logic [4:0] zoom;
	ref_coord_t x_start;
	ref_coord_t y_start;
	logic frame_busy;
	logic frame_done;
	logic pix_we;
	logic [ADDR_W-1:0] pix_addr;
	logic [7:0] pix_color;

	// Parameters of the frame being checked
	ref_coord_t frame_x;
	ref_coord_t frame_y;
	logic [4:0] frame_zoom;
	int expected_addr;
	int frame_writes;
	logic done_seen;

	int errors = 0;
	int checks = 0;

	mandelbrot_renderer #(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT),
		.ITER_MAX(ITER_MAX)
	) u_mandelbrot_renderer (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.zoom(zoom),
		.x_start(x_start),
		.y_start(y_start),
		.frame_busy(frame_busy),
		.frame_done(frame_done),
		.pix_we(pix_we),
		.pix_addr(pix_addr),
		.pix_color(pix_color)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: renderer did not finish its frames within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Compare process, sampled mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		ref_coord_t re;
		ref_coord_t im;
		logic [7:0] want;
		if (!reset && pix_we) begin
			ref_point(frame_x, frame_y, frame_zoom, expected_addr, re, im);
			want = ref_palette(ref_escape_count(re, im), ITER_MAX);
			checks += 2;
			assert (pix_addr == ADDR_W'(expected_addr)) else begin
				errors++;
				$display("Mismatch at %0t: write address %0d, expected %0d",
					$time, pix_addr, expected_addr);
			end
			assert (pix_color == want) else begin
				errors++;
				$display("Mismatch at %0t: colour %b at address %0d, expected %b",
					$time, pix_color, expected_addr, want);
			end
			expected_addr++;
			frame_writes++;
		end
		// Frame end only once every pixel is out
		if (!reset && frame_done && !done_seen) begin
			checks++;
			assert (frame_writes == PIXELS) else begin
				errors++;
				$display("Mismatch at %0t: frame_done after %0d writes, expected %0d",
					$time, frame_writes, PIXELS);
			end
		end
		done_seen = frame_done && !reset;
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic start_frame(input ref_coord_t x, input ref_coord_t y, input logic [4:0] z);
		@(posedge clk);
		#2;
		frame_x = x;
		frame_y = y;
		frame_zoom = z;
		expected_addr = 0;
		frame_writes = 0;
		x_start = x;
		y_start = y;
		zoom = z;
		frame_start = 1'b1;
		@(posedge clk);
		#2;
		frame_start = 1'b0;
		checks++;
		assert (frame_busy) else begin
			errors++;
			$display("frame_busy did not rise after frame_start at %0t", $time);
		end
	endtask

	task automatic wait_frame_done();
		while (frame_done !== 1'b1)
			@(negedge clk);
	endtask

	// Restart request mid-frame with other inputs, must be ignored
	task automatic pulse_start_while_busy(input int after_writes);
		while (frame_writes < after_writes)
			@(negedge clk);
		@(posedge clk);
		#2;
		checks++;
		assert (frame_busy) else begin
			errors++;
			$display("Renderer not busy when the ignored frame_start was sent at %0t", $time);
		end
		x_start = ref_coord_t'(0);
		y_start = ref_coord_t'(0);
		zoom = 5'd3;
		frame_start = 1'b1;
		@(posedge clk);
		#2;
		frame_start = 1'b0;
	endtask

	task automatic check_idle_outputs(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			checks++;
			assert (!frame_busy && !frame_done && !pix_we) else begin
				errors++;
				$display("Control outputs active before any frame_start at %0t", $time);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int unsigned seed_val;
		ref_coord_t x;
		ref_coord_t y;
		logic [4:0] z;
		seed_val = $urandom(18);
		reset = 1'b1;
		frame_start = 1'b0;
		zoom = '0;
		x_start = '0;
		y_start = '0;
		frame_x = '0;
		frame_y = '0;
		frame_zoom = '0;
		expected_addr = 0;
		frame_writes = 0;
		done_seen = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		check_idle_outputs(8);

		// Fixed window at zoom 0
		start_frame(X_FIRST, Y_FIRST, 5'd0);
		wait_frame_done();

		// Random zoom and offsets, second one gets a stray start
		for (int i = 0; i < 3; i++) begin
			z = 5'($urandom_range(6, 0));
			x = X_RAND_BASE + ref_coord_t'($urandom_range(1 << 18, 0));
			y = Y_RAND_BASE + ref_coord_t'($urandom_range(1 << 18, 0));
			start_frame(x, y, z);
			if (i == 1)
				pulse_start_while_busy(50);
			wait_frame_done();
		end

		repeat (2) @(posedge clk);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+bench
logic/fixed_point_pkg.sv
logic/render_pkg.sv
logic/iterate_if.sv
logic/escape_iterator.sv
logic/pixel_scanner.sv
logic/frame_sequencer.sv
logic/mandelbrot_renderer.sv
bench/renderer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module renderer_tb -o renderer_sim

./obj_dir/renderer_sim > sim.log
cat sim.log

if grep -q "^All checks passed$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
